//--- include/mem_if_config.svh
`ifndef MEM_IF_CONFIG_SVH
`define MEM_IF_CONFIG_SVH

// ------------------------------
// word port and line geometry
// ------------------------------

// word address width, one address per 32-bit word
`define MEM_ADDR_W 10

// 32-bit words held in one line
`define WORDS_PER_LINE 2

// line width in bits, words per line times 32
`define LINE_W 64

// ------------------------------
// cache, buffer and store sizing
// ------------------------------

// direct-mapped sets in the cache
`define CACHE_SETS 8

// pending line writes the write buffer can hold
`define WBUF_DEPTH 4

// store cycles from a strobe to its done pulse
`define MEM_LATENCY 6

// size reported on memmapsz, in words
`define MEMMAP_SIZE (1 << `MEM_ADDR_W)

`endif

//--- hdl/mem_if_pkg.sv
`include "mem_if_config.svh"

package mem_if_pkg;

	// address split between line and word offset
	localparam int WORD_OFS_W = $clog2(`WORDS_PER_LINE);
	localparam int LINE_ADDR_W = `MEM_ADDR_W - WORD_OFS_W;
	localparam int LINE_BYTES = `LINE_W / 8;

	// memory port operations
	typedef enum logic [1:0] {
		op_noop = 2'b00,
		op_write = 2'b01,
		op_read = 2'b10,
		op_read_write = 2'b11
	} mem_op_t;

	typedef logic [`MEM_ADDR_W-1:0] word_addr_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [`LINE_W-1:0] line_t;
	// one bit per byte of a line
	typedef logic [LINE_BYTES-1:0] line_mask_t;
	// fill level of the write buffer, 0 up to full
	typedef logic [$clog2(`WBUF_DEPTH + 1)-1:0] wbuf_count_t;

	// one pending line write, set mask bit means byte written
	typedef struct packed {
		line_addr_t addr;
		line_t data;
		line_mask_t mask;
	} wbuf_entry_t;

	// drop the word offset
	function automatic line_addr_t to_line_addr(word_addr_t a);
		return a[`MEM_ADDR_W-1:WORD_OFS_W];
	endfunction

	// word byte selects moved into the lane of the addressed word
	function automatic line_mask_t lane_mask(word_addr_t a, logic [3:0] sel);
		return line_mask_t'(sel) << (4 * a[WORD_OFS_W-1:0]);
	endfunction

	// byte mask widened to a bit mask
	function automatic line_t expand_mask(line_mask_t m);
		line_t bits;
		for (int i = 0; i < LINE_BYTES; i++) begin
			bits[8*i +: 8] = {8{m[i]}};
		end
		return bits;
	endfunction

	// addressed word out of a line
	function automatic logic [31:0] line_word(line_t l, word_addr_t a);
		return l[32*a[WORD_OFS_W-1:0] +: 32];
	endfunction

endpackage

//--- hdl/line_bus_if.sv
`timescale 1ns/100ps

// link between the backend sequencer and the line store
interface line_bus_if;
	import mem_if_pkg::*;

	// one-cycle strobes, never both high
	logic rd;
	logic wr;
	// line address and write payload, sampled with the strobe
	line_addr_t addr;
	line_t wdata;
	line_mask_t wmask;
	// read line, valid with done
	line_t rdata;
	// pulses MEM_LATENCY cycles after a strobe
	logic done;

	// sequencer side
	modport seq (
		output rd, wr, addr, wdata, wmask,
		input rdata, done
	);

	// store side
	modport store (
		input rd, wr, addr, wdata, wmask,
		output rdata, done
	);

endinterface

//--- hdl/write_buffer.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// circular FIFO of pending line writes, head always visible
module write_buffer #(
	parameter type entry_t = mem_if_pkg::wbuf_entry_t,
	parameter int DEPTH = `WBUF_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input entry_t din,
	output entry_t dout,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t slots [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// full push and empty pop are dropped
	assign do_push = push && (count != CNT_W'(DEPTH));
	assign do_pop = pop && (count != '0);
	assign dout = slots[rd_ptr];

	// wrap at DEPTH, not only at a power of two
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (do_push) begin
			slots[wr_ptr] <= din;
		end
	end

	// ------------------------------
	// pointers and fill count
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	// back-pressure upstream must keep writes out of a full buffer
	assert property (@(posedge clk) disable iff (rst) !(push && count == CNT_W'(DEPTH)));
	// drain side only pops what is there
	assert property (@(posedge clk) disable iff (rst) !(pop && count == '0));

endmodule

//--- hdl/line_cache.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// direct-mapped line cache with per-byte valid bits
module line_cache (
	input logic clk,
	input logic rst,
	input mem_if_pkg::word_addr_t addr,
	input logic [31:0] wdata,
	input logic [3:0] bytesel,
	input logic wr_en,
	input logic fill_en,
	input mem_if_pkg::word_addr_t fill_addr,
	input mem_if_pkg::line_t fill_data,
	input mem_if_pkg::line_mask_t fill_keep,
	output logic hit,
	output logic [31:0] rd_word,
	output mem_if_pkg::wbuf_entry_t entry
);
	import mem_if_pkg::*;

	localparam int SET_W = $clog2(`CACHE_SETS);
	localparam int TAG_W = LINE_ADDR_W - SET_W;

	logic [TAG_W-1:0] tags [`CACHE_SETS];
	line_t lines [`CACHE_SETS];
	line_mask_t valid [`CACHE_SETS];

	// lookup side, from the port address
	line_addr_t lk_line;
	logic [SET_W-1:0] lk_set;
	logic [TAG_W-1:0] lk_tag;
	logic tag_match;
	line_mask_t sel_mask;
	line_t sel_bits;
	line_t wr_data;
	// fill side, from the saved miss address
	line_addr_t fl_line;
	logic [SET_W-1:0] fl_set;
	logic [TAG_W-1:0] fl_tag;
	line_t keep_bits;

	assign lk_line = to_line_addr(addr);
	assign lk_set = lk_line[SET_W-1:0];
	assign lk_tag = lk_line[LINE_ADDR_W-1:SET_W];
	assign fl_line = to_line_addr(fill_addr);
	assign fl_set = fl_line[SET_W-1:0];
	assign fl_tag = fl_line[LINE_ADDR_W-1:SET_W];

	// word copied into every lane, the mask picks the right one
	assign wr_data = {`WORDS_PER_LINE{wdata}};
	assign sel_mask = lane_mask(addr, bytesel);
	assign sel_bits = expand_mask(sel_mask);
	assign keep_bits = expand_mask(fill_keep);

	// ------------------------------
	// hit and read
	// ------------------------------
	assign tag_match = tags[lk_set] == lk_tag;
	// every selected byte must be valid under the tag
	assign hit = tag_match && ((valid[lk_set] & sel_mask) == sel_mask);
	assign rd_word = line_word(lines[lk_set], addr);

	// same write, shaped for the write buffer
	assign entry = '{addr: lk_line, data: wr_data, mask: sel_mask};

	// ------------------------------
	// tag and data update
	// ------------------------------
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[fl_set] <= fl_tag;
			// bytes written by a pending read-write survive the fill
			lines[fl_set] <= (fill_data & ~keep_bits) | (lines[fl_set] & keep_bits);
		end else if (wr_en) begin
			tags[lk_set] <= lk_tag;
			lines[lk_set] <= (wr_data & sel_bits) | (lines[lk_set] & ~sel_bits);
		end
	end

	// byte-valid masks
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CACHE_SETS; i++) begin
				valid[i] <= '0;
			end
		end else if (fill_en) begin
			valid[fl_set] <= '1;
		end else if (wr_en) begin
			// other tag evicts, so the mask starts over
			valid[lk_set] <= (tag_match ? valid[lk_set] : '0) | sel_mask;
		end
	end

endmodule

//--- hdl/access_ctrl.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// ready state, miss bookkeeping and read data of the word port
module access_ctrl (
	input logic clk,
	input logic rst,
	input mem_if_pkg::mem_op_t memop,
	input mem_if_pkg::word_addr_t memaddr,
	input logic [3:0] bytesel,
	input logic hit,
	input logic [31:0] cache_word,
	input mem_if_pkg::wbuf_count_t wbuf_count,
	input logic fetch_done,
	input mem_if_pkg::line_t fetch_data,
	output logic memrdy,
	output logic [31:0] memdataout,
	output logic fetch_req,
	output logic rw_pending,
	output mem_if_pkg::word_addr_t saved_addr,
	output mem_if_pkg::line_mask_t saved_keep,
	output logic cache_wr
);
	import mem_if_pkg::*;

	logic accept;
	logic is_read;
	logic is_write;
	logic will_fill;

	// operation taken on this edge
	assign accept = memrdy && (memop != op_noop);
	assign is_read = (memop == op_read) || (memop == op_read_write);
	assign is_write = (memop == op_write) || (memop == op_read_write);
	// write goes to cache and buffer together
	assign cache_wr = accept && is_write;
	// this push takes the last free slot
	assign will_fill = wbuf_count == wbuf_count_t'(`WBUF_DEPTH - 1);

	// ------------------------------
	// ready, fetch request, read data
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			memrdy <= 1'b1;
			fetch_req <= 1'b0;
			rw_pending <= 1'b0;
			memdataout <= '0;
		end else if (!memrdy) begin
			if (fetch_done) begin
				// line arrived and the word goes out with memrdy
				memrdy <= 1'b1;
				fetch_req <= 1'b0;
				rw_pending <= 1'b0;
				memdataout <= line_word(fetch_data, saved_addr);
			end else if (!fetch_req && (wbuf_count != wbuf_count_t'(`WBUF_DEPTH))) begin
				// buffer has a free slot again
				memrdy <= 1'b1;
			end
		end else if (accept) begin
			// stall on a read miss or on a full buffer
			memrdy <= !(is_read && !hit) && !(is_write && will_fill);
			if (is_read) begin
				memdataout <= cache_word;
				fetch_req <= !hit;
				// a read-write miss leaves its own entry behind the fetch
				rw_pending <= !hit && (memop == op_read_write);
			end
		end
	end

	// miss address and the bytes the read-write put in the cache
	always_ff @(posedge clk) begin
		if (accept && is_read) begin
			saved_addr <= memaddr;
			saved_keep <= (memop == op_read_write) ? lane_mask(memaddr, bytesel) : '0;
		end
	end

	// the backend returns a line only to a pending miss
	assert property (@(posedge clk) disable iff (rst)
		fetch_done |-> (fetch_req && !memrdy));

endmodule

//--- hdl/backend_seq.sv
`timescale 1ns/100ps

// one store access at a time, buffer drains or a line fetch
module backend_seq (
	input logic clk,
	input logic rst,
	input mem_if_pkg::wbuf_count_t wbuf_count,
	input mem_if_pkg::wbuf_entry_t wbuf_head,
	input logic fetch_req,
	input logic rw_pending,
	input mem_if_pkg::line_addr_t fetch_addr,
	output logic wbuf_pop,
	output logic fetch_done,
	output mem_if_pkg::line_t fetch_data,
	line_bus_if.seq bus
);
	import mem_if_pkg::*;

	// access in flight, and whether it is the fetch
	logic busy;
	logic reading;
	logic fetch_ok;
	logic start_fetch;
	logic start_drain;

	// ------------------------------
	// issue decision
	// ------------------------------
	// fetch sees the store current: buffer empty, or only
	// the read-write entry that must land after the read
	assign fetch_ok = (wbuf_count == '0) ||
		(rw_pending && (wbuf_count == wbuf_count_t'(1)));
	assign start_fetch = !busy && fetch_req && fetch_ok;
	// otherwise keep draining
	assign start_drain = !busy && !start_fetch && (wbuf_count != '0);

	// strobes leave in the decision cycle, head popped with them
	assign bus.rd = start_fetch;
	assign bus.wr = start_drain;
	assign bus.addr = start_fetch ? fetch_addr : wbuf_head.addr;
	assign bus.wdata = wbuf_head.data;
	assign bus.wmask = wbuf_head.mask;
	assign wbuf_pop = start_drain;

	// ------------------------------
	// busy tracking
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			reading <= 1'b0;
		end else if (start_fetch || start_drain) begin
			busy <= 1'b1;
			reading <= start_fetch;
		end else if (bus.done) begin
			busy <= 1'b0;
			reading <= 1'b0;
		end
	end

	// line returned to the controller and cache
	assign fetch_done = busy && reading && bus.done;
	assign fetch_data = bus.rdata;

endmodule

//--- hdl/line_store.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// line-wide backing memory with a fixed access latency
module line_store (
	input logic clk,
	input logic rst,
	line_bus_if.store bus
);
	import mem_if_pkg::*;

	localparam int CNT_W = $clog2(`MEM_LATENCY);

	line_t mem [2**LINE_ADDR_W];
	line_addr_t addr_q;
	logic busy;
	logic [CNT_W-1:0] cnt;

	// contents start at zero
	initial begin
		for (int i = 0; i < 2**LINE_ADDR_W; i++) begin
			mem[i] = '0;
		end
	end

	// byte-masked write at the strobe, read line at the end
	always @(posedge clk) begin
		if (bus.wr) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (bus.wmask[b]) begin
					mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
		if (bus.rd) begin
			addr_q <= bus.addr;
		end
		if (busy && (cnt == CNT_W'(1))) begin
			bus.rdata <= mem[addr_q];
		end
	end

	// ------------------------------
	// latency counter and done
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			if (bus.rd || bus.wr) begin
				busy <= 1'b1;
				cnt <= CNT_W'(`MEM_LATENCY - 1);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_W'(1)) begin
					busy <= 1'b0;
					bus.done <= 1'b1;
				end
			end
		end
	end

	// sequencer waits for done before the next strobe
	assert property (@(posedge clk) disable iff (rst) (bus.rd || bus.wr) |-> !busy);

endmodule

//--- hdl/mem_if_top.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// cached word port in front of the line store
module mem_if_top (
	input logic clk,
	input logic rst,
	input mem_if_pkg::mem_op_t memop,
	input mem_if_pkg::word_addr_t memaddr,
	input logic [31:0] memdatain,
	input logic [3:0] membyteselect,
	output logic [31:0] memdataout,
	output logic memrdy,
	output logic [29:0] memmapsz
);
	import mem_if_pkg::*;

	// cache to controller and buffer
	logic hit;
	logic [31:0] cache_word;
	wbuf_entry_t cache_entry;
	logic cache_wr;
	// controller to sequencer and cache fill
	logic fetch_req;
	logic rw_pending;
	word_addr_t saved_addr;
	line_mask_t saved_keep;
	logic fetch_done;
	line_t fetch_data;
	// write buffer
	wbuf_entry_t wbuf_head;
	wbuf_count_t wbuf_count;
	logic wbuf_pop;

	line_bus_if bus ();

	// size in words
	assign memmapsz = 30'(`MEMMAP_SIZE);

	// ------------------------------
	// instances
	// ------------------------------
	write_buffer #(.entry_t(wbuf_entry_t), .DEPTH(`WBUF_DEPTH)) u_wbuf (
		.clk(clk), .rst(rst), .push(cache_wr), .pop(wbuf_pop),
		.din(cache_entry), .dout(wbuf_head), .count(wbuf_count)
	);

	line_cache u_cache (
		.clk(clk), .rst(rst), .addr(memaddr), .wdata(memdatain),
		.bytesel(membyteselect), .wr_en(cache_wr), .fill_en(fetch_done),
		.fill_addr(saved_addr), .fill_data(fetch_data), .fill_keep(saved_keep),
		.hit(hit), .rd_word(cache_word), .entry(cache_entry)
	);

	access_ctrl u_ctrl (
		.clk(clk), .rst(rst), .memop(memop), .memaddr(memaddr),
		.bytesel(membyteselect), .hit(hit), .cache_word(cache_word),
		.wbuf_count(wbuf_count), .fetch_done(fetch_done), .fetch_data(fetch_data),
		.memrdy(memrdy), .memdataout(memdataout), .fetch_req(fetch_req),
		.rw_pending(rw_pending), .saved_addr(saved_addr), .saved_keep(saved_keep),
		.cache_wr(cache_wr)
	);

	backend_seq u_seq (
		.clk(clk), .rst(rst), .wbuf_count(wbuf_count), .wbuf_head(wbuf_head),
		.fetch_req(fetch_req), .rw_pending(rw_pending),
		.fetch_addr(to_line_addr(saved_addr)), .wbuf_pop(wbuf_pop),
		.fetch_done(fetch_done), .fetch_data(fetch_data), .bus(bus.seq)
	);

	line_store u_store (.clk(clk), .rst(rst), .bus(bus.store));

endmodule

//--- verif/mem_if_model.svh
`ifndef MEM_IF_MODEL_SVH
`define MEM_IF_MODEL_SVH

// ------------------------------
// reference word memory
// ------------------------------

// one word per address, starts at zero like the line store
logic [31:0] model_mem [`MEMMAP_SIZE];

function automatic void clear_model();
	for (int i = 0; i < `MEMMAP_SIZE; i++) begin
		model_mem[i] = '0;
	end
endfunction

// byte selects widened to a bit mask
function automatic logic [31:0] byte_bits(logic [3:0] sel);
	logic [31:0] bits;
	for (int i = 0; i < 4; i++) begin
		bits[8*i +: 8] = {8{sel[i]}};
	end
	return bits;
endfunction

// selected bytes from the new word, the rest from the old one
function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
		logic [3:0] sel);
	return (old_word & ~byte_bits(sel)) | (new_word & byte_bits(sel));
endfunction

// one port operation on the model
// returns the word as it was before, which is what a read or read-write sees
function automatic logic [31:0] model_access(mem_op_t op, word_addr_t addr,
		logic [31:0] data, logic [3:0] sel);
	logic [31:0] old_word;
	old_word = model_mem[addr];
	if (op == op_write || op == op_read_write) begin
		model_mem[addr] = merge_bytes(old_word, data, sel);
	end
	return old_word;
endfunction

`endif

//--- verif/mem_if_tb.sv
`timescale 1ns/100ps
`include "mem_if_config.svh"

// testbench for the cached memory interface
module mem_if_tb;
	import mem_if_pkg::*;

	localparam int N_RANDOM = 300;
	// reads, partial writes, read-writes, burst and readback, random mix
	localparam int N_OPS = 2 + 5 + 6 + 2 * (`WBUF_DEPTH + 1) + N_RANDOM;
	localparam int SEED = 32'h6fe479e6;

	logic clk;
	logic rst;
	mem_op_t memop;
	word_addr_t memaddr;
	logic [31:0] memdatain;
	logic [3:0] membyteselect;
	logic [31:0] memdataout;
	logic memrdy;
	logic [29:0] memmapsz;

	// finished read waiting for the compare process
	typedef struct packed {
		word_addr_t addr;
		logic [31:0] got;
		logic [31:0] exp;
		logic [3:0] sel;
	} result_t;

	result_t results [$];
	int errors;
	int checks;
	int ops_issued;
	logic stall_seen;

	`include "mem_if_model.svh"

	mem_if_top UUT (
		.clk(clk), .rst(rst), .memop(memop), .memaddr(memaddr),
		.memdatain(memdatain), .membyteselect(membyteselect),
		.memdataout(memdataout), .memrdy(memrdy), .memmapsz(memmapsz)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------
	// checking
	// ------------------------------
	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// only the selected bytes of a read are defined
	always @(posedge clk) begin : compare_results
		result_t r;
		while (results.size() > 0) begin
			r = results.pop_front();
			check_value($sformatf("read data at %03h", r.addr),
				r.got & byte_bits(r.sel), r.exp & byte_bits(r.sel));
		end
	end

	// one operation on the port
	// fast is memrdy one cycle after acceptance
	task automatic run_op(input mem_op_t op, input word_addr_t addr, input logic [31:0] data,
			input logic [3:0] sel, output logic fast);
		result_t r;
		while (!memrdy) @(negedge clk);
		r.exp = model_access(op, addr, data, sel);
		memop = op;
		memaddr = addr;
		memdatain = data;
		membyteselect = sel;
		ops_issued++;
		// accepted on the rising edge in between
		@(negedge clk);
		memop = op_noop;
		fast = memrdy;
		if (!memrdy) begin
			stall_seen = 1'b1;
		end
		if (op == op_read || op == op_read_write) begin
			// word is out when memrdy is back
			while (!memrdy) @(negedge clk);
			r.addr = addr;
			r.got = memdataout;
			r.sel = sel;
			results.push_back(r);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin : stimulus
		logic fast;
		void'($urandom(SEED));
		rst = 1'b1;
		memop = op_noop;
		memaddr = '0;
		memdatain = '0;
		membyteselect = '0;
		errors = 0;
		checks = 0;
		ops_issued = 0;
		stall_seen = 1'b0;
		clear_model();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		// idle port after reset
		check_value("memrdy after reset", 32'(memrdy), 32'd1);
		check_value("memdataout after reset", memdataout, 32'd0);
		check_value("memmapsz", 32'(memmapsz), 32'd1024);
		// fresh address, miss then hit
		run_op(op_read, 10'h025, 32'd0, 4'hf, fast);
		check_value("first read misses", 32'(fast), 32'd0);
		run_op(op_read, 10'h025, 32'd0, 4'hf, fast);
		check_value("second read keeps memrdy", 32'(fast), 32'd1);
		// partial write, read on hit, then 046 evicted by 056 in set 3
		run_op(op_write, 10'h046, 32'h11223344, 4'hf, fast);
		run_op(op_write, 10'h046, 32'haabbccdd, 4'b0110, fast);
		run_op(op_read, 10'h046, 32'd0, 4'hf, fast);
		check_value("merged read hits", 32'(fast), 32'd1);
		run_op(op_write, 10'h056, 32'h0badf00d, 4'hf, fast);
		run_op(op_read, 10'h046, 32'd0, 4'hf, fast);
		check_value("evicted read misses", 32'(fast), 32'd0);
		// read-write on a hit
		run_op(op_read_write, 10'h046, 32'h55667788, 4'b1001, fast);
		check_value("read-write hit keeps memrdy", 32'(fast), 32'd1);
		run_op(op_read, 10'h046, 32'd0, 4'hf, fast);
		// read-write on a miss, 10a pushed out of set 5 first
		run_op(op_write, 10'h10a, 32'hcafe1234, 4'hf, fast);
		run_op(op_write, 10'h11a, 32'h13572468, 4'hf, fast);
		run_op(op_read_write, 10'h10a, 32'hdeadbeef, 4'b0011, fast);
		check_value("read-write miss stalls", 32'(fast), 32'd0);
		run_op(op_read, 10'h10a, 32'd0, 4'hf, fast);
		check_value("read after fill hits", 32'(fast), 32'd1);
		// burst one past the buffer depth
		stall_seen = 1'b0;
		for (int i = 0; i <= `WBUF_DEPTH; i++) begin
			run_op(op_write, word_addr_t'(10'h180 + 2 * i), $urandom, 4'hf, fast);
		end
		check_value("burst drops memrdy", 32'(stall_seen), 32'd1);
		for (int i = 0; i <= `WBUF_DEPTH; i++) begin
			run_op(op_read, word_addr_t'(10'h180 + 2 * i), 32'd0, 4'hf, fast);
		end
		// random mix, 96 words so sets see several tags
		for (int i = 0; i < N_RANDOM; i++) begin
			run_op(mem_op_t'($urandom_range(1, 3)), word_addr_t'($urandom_range(0, 95)),
				$urandom, 4'($urandom_range(1, 15)), fast);
		end
		// let the compare process empty its queue
		repeat (2) @(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog, worst case far below 400 cycles per operation
	initial begin : watchdog
		repeat (20 + N_OPS * 400) @(posedge clk);
		$display("timeout: the DUT stopped responding after %0d of %0d operations",
			ops_issued, N_OPS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
+incdir+verif
hdl/mem_if_pkg.sv
hdl/line_bus_if.sv
hdl/write_buffer.sv
hdl/line_cache.sv
hdl/access_ctrl.sv
hdl/backend_seq.sv
hdl/line_store.sv
hdl/mem_if_top.sv
verif/mem_if_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module mem_if_tb -o mem_if_sim &&
./obj_dir/mem_if_sim | tee /dev/stderr | grep -F "PASS: all tests" > /dev/null &&
echo "run.sh: simulation passed" ||
{
	echo "run.sh: simulation failed"
	exit 1
}
